//--- logic/frame_consts.svh
`ifndef FRAME_CONSTS_SVH
`define FRAME_CONSTS_SVH

// Camera frame size
`define FRAME_W         16
`define FRAME_H         12
`define FRAME_PIXELS    (`FRAME_W * `FRAME_H)

// Display window and the position of the camera region in it
`define DISP_W          32
`define DISP_H          24
`define WIN_X0          8
`define WIN_Y0          6

// Receive buffering
`define FIFO_DEPTH      256
`define FILL_THRESHOLD  (`FRAME_PIXELS / 4)

// Edge magnitude ceiling, the full 6-bit green range
`define GRAY_MAX        63

`endif

//--- logic/frame_pkg.sv
package frame_pkg;

    // RGB565 pixel
    typedef logic [15:0] pixel_t;
    typedef logic [7:0]  pix_addr_t;
    typedef logic [8:0]  fifo_count_t;
    typedef logic [5:0]  coord_t;
    // Luminance is the green field of a pixel
    typedef logic [5:0]  gray_t;

    typedef struct packed {
        logic      en;
        pix_addr_t addr;
        pixel_t    data;
    } buf_wr_t;

    typedef struct packed {
        logic       frame_ready;
        logic       edge_mode;
        logic [1:0] state_lo;
    } frame_status_t;

    typedef enum logic [1:0] {
        IDLE           = 2'd0,
        WRITE_FRAME    = 2'd1,
        FRAME_COMPLETE = 2'd2,
        EDGE_PROCESS   = 2'd3
    } capture_state_t;

endpackage

//--- logic/pixel_fifo.sv
`include "frame_consts.svh"

module pixel_fifo (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pix_valid,
    input  frame_pkg::pixel_t      pix_data,
    input  logic                   pop,
    output logic                   pix_ready,
    output frame_pkg::pixel_t      data,
    output frame_pkg::fifo_count_t count
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    frame_pkg::pixel_t mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic              push;
    logic              take;

    assign pix_ready = (count != frame_pkg::fifo_count_t'(`FIFO_DEPTH));
    assign push      = pix_valid && pix_ready;
    // A pop on an empty FIFO is ignored
    assign take      = pop && (count != '0);

    // Show-ahead head pixel
    assign data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= pix_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count unchanged
            case ({push, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- logic/frame_buffer.sv
`include "frame_consts.svh"

module frame_buffer (
    input  logic                 clk,
    input  frame_pkg::buf_wr_t   wr,
    input  frame_pkg::pix_addr_t rd_addr,
    output frame_pkg::pixel_t    rd_data
);

    frame_pkg::pixel_t mem [`FRAME_PIXELS];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Read data appears one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- logic/sobel_engine.sv
`include "frame_consts.svh"

module sobel_engine (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  frame_pkg::pixel_t    rd_data,
    output frame_pkg::pix_addr_t rd_addr,
    output frame_pkg::buf_wr_t   wr,
    output logic                 done
);

    typedef enum logic [2:0] {
        E_IDLE,
        E_PIXEL,
        E_READ,
        E_DRAIN,
        E_WRITE,
        E_FINISH
    } step_t;

    step_t                step;
    frame_pkg::coord_t    x;
    frame_pkg::coord_t    y;
    logic [1:0]           tr;
    logic [1:0]           tc;
    logic [1:0]           tr_d;
    logic [1:0]           tc_d;
    logic                 tap_vld;
    logic signed [9:0]    gx_sum;
    logic signed [9:0]    gy_sum;
    logic signed [9:0]    g1;
    logic signed [9:0]    g2;
    logic signed [9:0]    term_x;
    logic signed [9:0]    term_y;
    logic [9:0]           abs_sum;
    frame_pkg::gray_t     gray;
    frame_pkg::gray_t     mag;
    frame_pkg::pix_addr_t cur_addr;
    logic                 border;
    logic                 last_pix;

    assign gray     = rd_data[10:5];
    assign border   = (x == '0) || (y == '0) ||
                      (x == frame_pkg::coord_t'(`FRAME_W - 1)) ||
                      (y == frame_pkg::coord_t'(`FRAME_H - 1));
    assign last_pix = (x == frame_pkg::coord_t'(`FRAME_W - 1)) &&
                      (y == frame_pkg::coord_t'(`FRAME_H - 1));

    // Neighbour address for the current tap, row tr and column tc
    always_comb begin
        int nx;
        int ny;
        nx       = int'(x) + int'(tc) - 1;
        ny       = int'(y) + int'(tr) - 1;
        rd_addr  = frame_pkg::pix_addr_t'(ny * `FRAME_W + nx);
        cur_addr = frame_pkg::pix_addr_t'(int'(y) * `FRAME_W + int'(x));
    end

    // Kernel weights of the tap whose data is arriving now
    always_comb begin
        g1 = signed'({4'b0000, gray});
        g2 = g1 <<< 1;
        case (tc_d)
            2'd0:    term_x = (tr_d == 2'd1) ? -g2 : -g1;
            2'd2:    term_x = (tr_d == 2'd1) ? g2 : g1;
            default: term_x = '0;
        endcase
        case (tr_d)
            2'd0:    term_y = (tc_d == 2'd1) ? -g2 : -g1;
            2'd2:    term_y = (tc_d == 2'd1) ? g2 : g1;
            default: term_y = '0;
        endcase
    end

    // |Gx| + |Gy| saturated to the green range
    always_comb begin
        logic [9:0] ax;
        logic [9:0] ay;
        ax      = gx_sum[9] ? 10'(-gx_sum) : 10'(gx_sum);
        ay      = gy_sum[9] ? 10'(-gy_sum) : 10'(gy_sum);
        abs_sum = ax + ay;
        mag     = (abs_sum > 10'(`GRAY_MAX)) ? frame_pkg::gray_t'(`GRAY_MAX) : abs_sum[5:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step    <= E_IDLE;
            x       <= '0;
            y       <= '0;
            tr      <= '0;
            tc      <= '0;
            tr_d    <= '0;
            tc_d    <= '0;
            tap_vld <= 1'b0;
            gx_sum  <= '0;
            gy_sum  <= '0;
            wr      <= '0;
            done    <= 1'b0;
        end else begin
            wr.en   <= 1'b0;
            done    <= 1'b0;
            tap_vld <= 1'b0;
            if (tap_vld) begin
                gx_sum <= gx_sum + term_x;
                gy_sum <= gy_sum + term_y;
            end
            case (step)
                E_IDLE: begin
                    if (start) begin
                        x    <= '0;
                        y    <= '0;
                        step <= E_PIXEL;
                    end
                end
                E_PIXEL: begin
                    gx_sum <= '0;
                    gy_sum <= '0;
                    tr     <= '0;
                    tc     <= '0;
                    // Border pixels skip the reads and write zero
                    step   <= border ? E_WRITE : E_READ;
                end
                E_READ: begin
                    tr_d    <= tr;
                    tc_d    <= tc;
                    tap_vld <= 1'b1;
                    if (tc == 2'd2) begin
                        tc <= '0;
                        if (tr == 2'd2) begin
                            step <= E_DRAIN;
                        end else begin
                            tr <= tr + 1'b1;
                        end
                    end else begin
                        tc <= tc + 1'b1;
                    end
                end
                // Last tap lands in the sums here
                E_DRAIN: step <= E_WRITE;
                E_WRITE: begin
                    wr <= '{en: 1'b1, addr: cur_addr, data: {mag[5:1], mag, mag[5:1]}};
                    if (last_pix) begin
                        step <= E_FINISH;
                    end else begin
                        if (x == frame_pkg::coord_t'(`FRAME_W - 1)) begin
                            x <= '0;
                            y <= y + 1'b1;
                        end else begin
                            x <= x + 1'b1;
                        end
                        step <= E_PIXEL;
                    end
                end
                E_FINISH: begin
                    done <= 1'b1;
                    step <= E_IDLE;
                end
                default: step <= E_IDLE;
            endcase
        end
    end

endmodule

//--- logic/frame_controller.sv
`include "frame_consts.svh"

module frame_controller (
    input  logic                     clk,
    input  logic                     rst_n,
    input  frame_pkg::fifo_count_t   fifo_count,
    input  frame_pkg::pixel_t        fifo_data,
    input  logic                     edge_mode,
    input  logic                     edge_done,
    input  frame_pkg::pix_addr_t     engine_rd_addr,
    input  frame_pkg::pixel_t        raw_rd_data,
    input  frame_pkg::pixel_t        edge_rd_data,
    input  logic                     disp_req,
    input  frame_pkg::coord_t        disp_x,
    input  frame_pkg::coord_t        disp_y,
    output logic                     fifo_pop,
    output frame_pkg::buf_wr_t       raw_wr,
    output frame_pkg::pix_addr_t     raw_rd_addr,
    output frame_pkg::pix_addr_t     edge_rd_addr,
    output logic                     edge_start,
    output logic                     disp_valid,
    output frame_pkg::pixel_t        disp_data,
    output frame_pkg::frame_status_t status
);

    frame_pkg::capture_state_t state;
    frame_pkg::pix_addr_t      wr_addr;
    frame_pkg::pix_addr_t      disp_addr;
    logic                      frame_ready;
    logic                      edge_valid;
    logic                      in_win;
    logic                      blank;
    logic                      req_d1;
    logic                      blank_d1;
    logic                      edge_sel_d1;

    // Pixels move straight from the FIFO head into the raw buffer
    assign fifo_pop = (state == frame_pkg::WRITE_FRAME) && (fifo_count != '0);
    assign raw_wr   = '{en: fifo_pop, addr: wr_addr, data: fifo_data};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= frame_pkg::IDLE;
            wr_addr     <= '0;
            frame_ready <= 1'b0;
            edge_valid  <= 1'b0;
            edge_start  <= 1'b0;
        end else begin
            edge_start <= 1'b0;
            case (state)
                frame_pkg::IDLE: begin
                    if (fifo_count >= frame_pkg::fifo_count_t'(`FILL_THRESHOLD)) begin
                        state       <= frame_pkg::WRITE_FRAME;
                        wr_addr     <= '0;
                        frame_ready <= 1'b0;
                        edge_valid  <= 1'b0;
                    end
                end
                frame_pkg::WRITE_FRAME: begin
                    if (fifo_pop) begin
                        wr_addr <= wr_addr + 1'b1;
                        if (wr_addr == frame_pkg::pix_addr_t'(`FRAME_PIXELS - 1)) begin
                            state       <= frame_pkg::FRAME_COMPLETE;
                            frame_ready <= 1'b1;
                        end
                    end else if (wr_addr > frame_pkg::pix_addr_t'(`FRAME_PIXELS / 2)) begin
                        // Starved, but more than half a frame is good enough
                        state       <= frame_pkg::FRAME_COMPLETE;
                        frame_ready <= 1'b1;
                    end else begin
                        state <= frame_pkg::IDLE;
                    end
                end
                frame_pkg::FRAME_COMPLETE: begin
                    if (edge_mode) begin
                        state      <= frame_pkg::EDGE_PROCESS;
                        edge_start <= 1'b1;
                    end else if (fifo_count >= frame_pkg::fifo_count_t'(`FILL_THRESHOLD)) begin
                        state       <= frame_pkg::WRITE_FRAME;
                        wr_addr     <= '0;
                        frame_ready <= 1'b0;
                        edge_valid  <= 1'b0;
                    end
                end
                frame_pkg::EDGE_PROCESS: begin
                    if (edge_done) begin
                        state      <= frame_pkg::IDLE;
                        edge_valid <= 1'b1;
                    end
                end
                default: state <= frame_pkg::IDLE;
            endcase
        end
    end

    // Display window to frame address, black outside the camera region
    always_comb begin
        int fx;
        int fy;
        fx        = int'(disp_x) - `WIN_X0;
        fy        = int'(disp_y) - `WIN_Y0;
        in_win    = (fx >= 0) && (fx < `FRAME_W) && (fy >= 0) && (fy < `FRAME_H);
        disp_addr = in_win ? frame_pkg::pix_addr_t'(fy * `FRAME_W + fx) : '0;
    end

    assign blank = !in_win || !frame_ready || (state == frame_pkg::EDGE_PROCESS) ||
                   (edge_mode && !edge_valid);

    // Raw read port belongs to the engine while it runs
    assign raw_rd_addr  = (state == frame_pkg::EDGE_PROCESS) ? engine_rd_addr : disp_addr;
    assign edge_rd_addr = disp_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_d1     <= 1'b0;
            disp_valid <= 1'b0;
        end else begin
            req_d1     <= disp_req;
            disp_valid <= req_d1;
        end
    end

    // Decision travels alongside the buffer read
    always_ff @(posedge clk) begin
        blank_d1    <= blank;
        edge_sel_d1 <= edge_mode;
        disp_data   <= blank_d1 ? '0 : (edge_sel_d1 ? edge_rd_data : raw_rd_data);
    end

    assign status = '{frame_ready: frame_ready, edge_mode: edge_mode, state_lo: state};

endmodule

//--- logic/frame_system_top.sv
module frame_system_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pix_valid,
    input  frame_pkg::pixel_t        pix_data,
    output logic                     pix_ready,
    input  logic                     edge_mode,
    input  logic                     disp_req,
    input  frame_pkg::coord_t        disp_x,
    input  frame_pkg::coord_t        disp_y,
    output logic                     disp_valid,
    output frame_pkg::pixel_t        disp_data,
    output frame_pkg::frame_status_t status
);

    frame_pkg::fifo_count_t fifo_count;
    frame_pkg::pixel_t      fifo_data;
    logic                   fifo_pop;
    frame_pkg::buf_wr_t     raw_wr;
    frame_pkg::buf_wr_t     edge_wr;
    frame_pkg::pix_addr_t   raw_rd_addr;
    frame_pkg::pix_addr_t   edge_rd_addr;
    frame_pkg::pix_addr_t   engine_rd_addr;
    frame_pkg::pixel_t      raw_rd_data;
    frame_pkg::pixel_t      edge_rd_data;
    logic                   edge_start;
    logic                   edge_done;

    pixel_fifo i_pixel_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pop       (fifo_pop),
        .pix_ready (pix_ready),
        .data      (fifo_data),
        .count     (fifo_count)
    );

    // Captured frame
    frame_buffer raw_buffer (
        .clk     (clk),
        .wr      (raw_wr),
        .rd_addr (raw_rd_addr),
        .rd_data (raw_rd_data)
    );

    // Edge image
    frame_buffer edge_buffer (
        .clk     (clk),
        .wr      (edge_wr),
        .rd_addr (edge_rd_addr),
        .rd_data (edge_rd_data)
    );

    sobel_engine i_sobel_engine (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (edge_start),
        .rd_data (raw_rd_data),
        .rd_addr (engine_rd_addr),
        .wr      (edge_wr),
        .done    (edge_done)
    );

    frame_controller i_frame_controller (
        .clk            (clk),
        .rst_n          (rst_n),
        .fifo_count     (fifo_count),
        .fifo_data      (fifo_data),
        .edge_mode      (edge_mode),
        .edge_done      (edge_done),
        .engine_rd_addr (engine_rd_addr),
        .raw_rd_data    (raw_rd_data),
        .edge_rd_data   (edge_rd_data),
        .disp_req       (disp_req),
        .disp_x         (disp_x),
        .disp_y         (disp_y),
        .fifo_pop       (fifo_pop),
        .raw_wr         (raw_wr),
        .raw_rd_addr    (raw_rd_addr),
        .edge_rd_addr   (edge_rd_addr),
        .edge_start     (edge_start),
        .disp_valid     (disp_valid),
        .disp_data      (disp_data),
        .status         (status)
    );

endmodule

//--- testbench/frame_system_assert.sv
module frame_system_assert (
    input  logic                     clk,
    input  logic                     rst_n,
    input  frame_pkg::fifo_count_t   fifo_count,
    input  logic                     fifo_pop,
    input  logic                     edge_start,
    input  logic                     disp_req,
    input  logic                     disp_valid,
    input  frame_pkg::frame_status_t status
);
    timeunit 1ns;
    timeprecision 1ps;

    // A pop takes exactly one pixel, so the count drops by one or holds on a push
    pop_takes_one: assert property (
        @(posedge clk) disable iff (!rst_n)
        fifo_pop |=> (fifo_count == $past(fifo_count)) ||
                     (fifo_count == $past(fifo_count) - 1'b1)
    ) else $error("fifo_pop did not remove exactly one pixel from the FIFO");

    // Engine start is a single-cycle pulse
    start_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) edge_start |=> !edge_start
    ) else $error("edge_start held high for more than one cycle");

    // One response per request, two cycles later
    disp_latency: assert property (
        @(posedge clk) disable iff (!rst_n) disp_valid == $past(disp_req, 2)
    ) else $error("disp_valid does not follow disp_req by two cycles");

    status_in_reset: assert property (
        @(posedge clk) !rst_n |-> (status == '0)
    ) else $error("status word not zero during reset");

endmodule

//--- testbench/frame_checker.sv
module frame_checker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     disp_req,
    input  frame_pkg::pixel_t        exp_data,
    input  logic                     disp_valid,
    input  frame_pkg::pixel_t        disp_data,
    input  logic                     status_chk,
    input  frame_pkg::frame_status_t exp_status,
    input  logic                     exp_ready,
    input  frame_pkg::frame_status_t status,
    input  logic                     pix_ready,
    output int                       errors,
    output int                       checks,
    output int                       pending
);
    timeunit 1ns;
    timeprecision 1ps;

    // Expected display values, oldest request first
    frame_pkg::pixel_t exp_q [$];
    frame_pkg::pixel_t want;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_q.delete();
            errors  = 0;
            checks  = 0;
            pending = 0;
        end else begin
            // Responses are compared before this cycle's request joins the queue
            if (disp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR: display response arrived with no request outstanding");
                    errors++;
                end else begin
                    want = exp_q.pop_front();
                    checks++;
                    if (disp_data !== want) begin
                        $display("MISMATCH disp_data: expected 0x%04h, got 0x%04h",
                                 want, disp_data);
                        errors++;
                    end
                end
            end
            if (disp_req) begin
                exp_q.push_back(exp_data);
            end
            if (status_chk) begin
                checks++;
                if (status !== exp_status) begin
                    $display("MISMATCH status: expected 0x%01h, got 0x%01h",
                             exp_status, status);
                    errors++;
                end
                if (pix_ready !== exp_ready) begin
                    $display("MISMATCH pix_ready: expected 0x%01h, got 0x%01h",
                             exp_ready, pix_ready);
                    errors++;
                end
            end
            pending = exp_q.size();
        end
    end

endmodule

//--- testbench/tb_frame_system.sv
`include "frame_consts.svh"

module tb_frame_system;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 8;
    localparam int STREAM_PIX   = 60 + `FRAME_PIXELS;
    localparam int READ_CYCLES  = 4 * `FRAME_PIXELS + 64;
    localparam int SOBEL_CYCLES = `FRAME_PIXELS * 10;
    localparam int WATCHDOG_CYCLES = 2 * STREAM_PIX + READ_CYCLES + 2 * SOBEL_CYCLES + 500;

    logic                     clk;
    logic                     rst_n;
    logic                     pix_valid;
    frame_pkg::pixel_t        pix_data;
    logic                     pix_ready;
    logic                     edge_mode;
    logic                     disp_req;
    frame_pkg::coord_t        disp_x;
    frame_pkg::coord_t        disp_y;
    logic                     disp_valid;
    frame_pkg::pixel_t        disp_data;
    frame_pkg::frame_status_t status;
    frame_pkg::pixel_t        exp_data;
    logic                     status_chk;
    frame_pkg::frame_status_t exp_status;
    logic                     exp_ready;
    int                       chk_errors;
    int                       chk_count;
    int                       pending;
    int                       wait_errors;
    int                       errors_before;
    int                       tests_run;
    integer                   seed;

    // Pixels of the last complete frame, in raster order
    frame_pkg::pixel_t frame_mem [`FRAME_PIXELS];

    frame_system_top i_frame_system_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data),
        .pix_ready  (pix_ready),
        .edge_mode  (edge_mode),
        .disp_req   (disp_req),
        .disp_x     (disp_x),
        .disp_y     (disp_y),
        .disp_valid (disp_valid),
        .disp_data  (disp_data),
        .status     (status)
    );

    frame_checker i_frame_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .disp_req   (disp_req),
        .exp_data   (exp_data),
        .disp_valid (disp_valid),
        .disp_data  (disp_data),
        .status_chk (status_chk),
        .exp_status (exp_status),
        .exp_ready  (exp_ready),
        .status     (status),
        .pix_ready  (pix_ready),
        .errors     (chk_errors),
        .checks     (chk_count),
        .pending    (pending)
    );

    bind frame_controller frame_system_assert i_frame_system_assert (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_count (fifo_count),
        .fifo_pop   (fifo_pop),
        .edge_start (edge_start),
        .disp_req   (disp_req),
        .disp_valid (disp_valid),
        .status     (status)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    function automatic int green_at(int fx, int fy);
        frame_pkg::pixel_t p;
        p = frame_mem[fy * `FRAME_W + fx];
        return int'(p[10:5]);
    endfunction

    function automatic frame_pkg::pixel_t expected_pixel(int dx, int dy, bit edge_img,
                                                         bit ready);
        int               fx;
        int               fy;
        int               gx;
        int               gy;
        int               mag;
        frame_pkg::gray_t g;
        fx = dx - `WIN_X0;
        fy = dy - `WIN_Y0;
        // Black outside the camera region and while no frame is held
        if (!ready || fx < 0 || fx >= `FRAME_W || fy < 0 || fy >= `FRAME_H) begin
            return '0;
        end
        if (!edge_img) begin
            return frame_mem[fy * `FRAME_W + fx];
        end
        if (fx == 0 || fy == 0 || fx == `FRAME_W - 1 || fy == `FRAME_H - 1) begin
            return '0;
        end
        gx = green_at(fx + 1, fy - 1) + 2 * green_at(fx + 1, fy) + green_at(fx + 1, fy + 1)
           - green_at(fx - 1, fy - 1) - 2 * green_at(fx - 1, fy) - green_at(fx - 1, fy + 1);
        gy = green_at(fx - 1, fy + 1) + 2 * green_at(fx, fy + 1) + green_at(fx + 1, fy + 1)
           - green_at(fx - 1, fy - 1) - 2 * green_at(fx, fy - 1) - green_at(fx + 1, fy - 1);
        mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
        if (mag > `GRAY_MAX) begin
            mag = `GRAY_MAX;
        end
        g = frame_pkg::gray_t'(mag);
        // Grey pixel, red and blue take the top five magnitude bits
        return {g[5:1], g, g[5:1]};
    endfunction

    function automatic frame_pkg::frame_status_t make_status(logic ready, logic mode,
                                                             frame_pkg::capture_state_t st);
        frame_pkg::frame_status_t s;
        s.frame_ready = ready;
        s.edge_mode   = mode;
        s.state_lo    = st;
        return s;
    endfunction

    task automatic send_pixels(int n, bit keep);
        int i;
        for (i = 0; i < n; i++) begin
            @(negedge clk);
            pix_valid = 1'b1;
            pix_data  = frame_pkg::pixel_t'($random(seed));
            if (keep) begin
                frame_mem[i] = pix_data;
            end
            @(posedge clk);
            while (!pix_ready) begin
                @(posedge clk);
            end
        end
        @(negedge clk);
        pix_valid = 1'b0;
    endtask

    task automatic wait_for_status(frame_pkg::frame_status_t want, int limit);
        int n;
        n = 0;
        while (status !== want && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (status !== want) begin
            $display("ERROR: status stuck at 0x%01h, expected 0x%01h within %0d cycles",
                     status, want, limit);
            wait_errors++;
        end
    endtask

    task automatic check_status(frame_pkg::frame_status_t want, logic ready);
        @(negedge clk);
        status_chk = 1'b1;
        exp_status = want;
        exp_ready  = ready;
        @(negedge clk);
        status_chk = 1'b0;
    endtask

    task automatic read_point(int dx, int dy, bit edge_img, bit ready);
        @(negedge clk);
        disp_req = 1'b1;
        disp_x   = frame_pkg::coord_t'(dx);
        disp_y   = frame_pkg::coord_t'(dy);
        exp_data = expected_pixel(dx, dy, edge_img, ready);
    endtask

    task automatic drain_reads();
        int n;
        @(negedge clk);
        disp_req = 1'b0;
        n = 0;
        while (pending != 0 && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (pending != 0) begin
            $display("ERROR: %0d display responses never arrived", pending);
            wait_errors++;
        end
    endtask

    // Every camera pixel back-to-back in raster order
    task automatic read_window(bit edge_img, bit ready);
        int dx;
        int dy;
        for (dy = `WIN_Y0; dy < `WIN_Y0 + `FRAME_H; dy++) begin
            for (dx = `WIN_X0; dx < `WIN_X0 + `FRAME_W; dx++) begin
                read_point(dx, dy, edge_img, ready);
            end
        end
        drain_reads();
    endtask

    task automatic end_test(string name);
        int n;
        n = chk_errors + wait_errors - errors_before;
        tests_run++;
        if (n == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, n);
        end
        errors_before = chk_errors + wait_errors;
    endtask

    initial begin
        seed          = 32'heba1;
        rst_n         = 1'b0;
        pix_valid     = 1'b0;
        pix_data      = '0;
        edge_mode     = 1'b0;
        disp_req      = 1'b0;
        disp_x        = '0;
        disp_y        = '0;
        exp_data      = '0;
        status_chk    = 1'b0;
        exp_status    = '0;
        exp_ready     = 1'b0;
        wait_errors   = 0;
        errors_before = 0;
        tests_run     = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Any stray disp_valid is caught by the checker
        check_status(make_status(1'b0, 1'b0, frame_pkg::IDLE), 1'b1);
        repeat (4) @(negedge clk);
        end_test("reset");

        // Above the quarter threshold but not over half a frame
        send_pixels(60, 1'b0);
        wait_for_status(make_status(1'b0, 1'b0, frame_pkg::IDLE), 2 * `FRAME_PIXELS);
        check_status(make_status(1'b0, 1'b0, frame_pkg::IDLE), 1'b1);
        read_window(1'b0, 1'b0);
        end_test("abandoned frame");

        send_pixels(`FRAME_PIXELS, 1'b1);
        wait_for_status(make_status(1'b1, 1'b0, frame_pkg::FRAME_COMPLETE),
                        2 * `FRAME_PIXELS);
        check_status(make_status(1'b1, 1'b0, frame_pkg::FRAME_COMPLETE), 1'b1);
        read_window(1'b0, 1'b1);
        end_test("raw frame");

        read_point(0, 0, 1'b0, 1'b1);
        read_point(`WIN_X0 - 1, `WIN_Y0, 1'b0, 1'b1);
        read_point(`WIN_X0 + `FRAME_W, `WIN_Y0, 1'b0, 1'b1);
        read_point(`WIN_X0, `WIN_Y0 - 1, 1'b0, 1'b1);
        read_point(`WIN_X0, `WIN_Y0 + `FRAME_H, 1'b0, 1'b1);
        read_point(`DISP_W - 1, `DISP_H - 1, 1'b0, 1'b1);
        read_point(63, 63, 1'b0, 1'b1);
        drain_reads();
        end_test("outside window");

        @(negedge clk);
        edge_mode = 1'b1;
        wait_for_status(make_status(1'b1, 1'b1, frame_pkg::IDLE), 2 * SOBEL_CYCLES);
        check_status(make_status(1'b1, 1'b1, frame_pkg::IDLE), 1'b1);
        read_window(1'b1, 1'b1);
        end_test("edge mode");

        @(negedge clk);
        edge_mode = 1'b0;
        wait_for_status(make_status(1'b1, 1'b0, frame_pkg::IDLE), 16);
        check_status(make_status(1'b1, 1'b0, frame_pkg::IDLE), 1'b1);
        read_window(1'b0, 1'b1);
        end_test("mode switch");

        $display("%0d tests, %0d checks, %0d errors",
                 tests_run, chk_count, chk_errors + wait_errors);
        if (chk_errors + wait_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+logic
logic/frame_pkg.sv
logic/pixel_fifo.sv
logic/frame_buffer.sv
logic/sobel_engine.sv
logic/frame_controller.sv
logic/frame_system_top.sv
testbench/frame_system_assert.sv
testbench/frame_checker.sv
testbench/tb_frame_system.sv

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --timing --assert -j 0 \
    --top-module tb_frame_system --Mdir build -o sim_frame_system \
    -f compile.f > build/build.log 2>&1 \
    || { cat build/build.log; echo "Build failed"; exit 1; }

build/sim_frame_system > build/sim.log 2>&1
cat build/sim.log

grep -q "TB FAILED" build/sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TB PASSED" build/sim.log && { echo "Simulation passed"; exit 0; }
echo "Simulation ended without a result"
exit 1
